// ==== logic/imgproc_pkg.sv ====
// frame size fixed at 640x480, one red hue range only, all hsv values on the 0..255 scale
package imgproc_pkg;

	////////////////////
	// frame geometry
	////////////////////

	localparam int image_w   = 640;
	localparam int image_h   = 480;
	// pixels within this margin of any edge count as border
	localparam int border_px = 20;

	typedef logic [10:0] coord_t;

	////////////////////
	// stream types
	////////////////////

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// one stream beat, 26 bits
	typedef struct packed {
		rgb_t data;
		logic sop;
		logic eop;
	} beat_t;

	// col_none must stay 0, the tracker indexes boxes by value minus one
	typedef enum logic [2:0] {
		col_none,
		col_red,
		col_green,
		col_blue,
		col_violet,
		col_yellow
	} ball_colour_e;

	localparam int n_colours = 5;

	////////////////////
	// colour ranges
	////////////////////

	// h_lo above h_hi means the hue range wraps through 0
	typedef struct packed {
		logic [7:0] h_lo;
		logic [7:0] h_hi;
		logic [7:0] s_lo;
		logic [7:0] s_hi;
		logic [7:0] v_lo;
		logic [7:0] v_hi;
	} hsv_range_t;

	localparam hsv_range_t range_red    = '{8'd170, 8'd25, 8'd149, 8'd232, 8'd125, 8'd200};
	localparam hsv_range_t range_green  = '{8'd60, 8'd80, 8'd75, 8'd200, 8'd50, 8'd128};
	localparam hsv_range_t range_blue   = '{8'd90, 8'd120, 8'd76, 8'd195, 8'd25, 8'd128};
	// violet has no lower hue limit, so it wraps from 255
	localparam hsv_range_t range_violet = '{8'd255, 8'd15, 8'd80, 8'd150, 8'd75, 8'd125};
	localparam hsv_range_t range_yellow = '{8'd25, 8'd45, 8'd100, 8'd153, 8'd102, 8'd245};

	// flat highlight colours
	localparam rgb_t high_red    = 24'hff0001;
	localparam rgb_t high_green  = 24'h00ff00;
	localparam rgb_t high_blue   = 24'h0000ff;
	localparam rgb_t high_violet = 24'h8e1596;
	localparam rgb_t high_yellow = 24'hedff6f;

	////////////////////
	// tracker and buffer
	////////////////////

	// fire marks a beat accepted by the out stage
	typedef struct packed {
		logic         fire;
		logic         sop;
		logic         eop;
		logic         video;
		coord_t       x;
		coord_t       y;
		ball_colour_e colour;
	} pix_info_t;

	typedef struct packed {
		coord_t xmin;
		coord_t ymin;
		coord_t xmax;
		coord_t ymax;
	} box_t;

	typedef logic [31:0] msg_word_t;
	typedef logic [7:0]  msg_count_t;

	localparam int msg_depth    = 128;
	localparam int msg_ptr_w    = $clog2(msg_depth);
	localparam int msg_interval = 6;

	typedef enum logic [1:0] {
		phase_idle,
		phase_id,
		phase_top_left,
		phase_bottom_right
	} msg_phase_e;

	////////////////////
	// register port
	////////////////////

	typedef enum logic [2:0] {
		addr_status = 3'd0,
		addr_msg    = 3'd1,
		addr_id     = 3'd2
	} reg_addr_e;

	localparam msg_word_t core_id   = 32'h1234EEE2;
	localparam int        flush_bit = 4;

endpackage

// ==== logic/stream_stage.sv ====
// holds one beat, ready stays low until the first clock edge after reset is released
module stream_stage import imgproc_pkg::*; (
	input  logic  clk,
	input  logic  reset_n,
	input  beat_t in_data,
	input  logic  in_valid,
	output logic  in_ready,
	output beat_t out_data,
	output logic  out_valid,
	input  logic  out_ready
);

	// set once reset has been released
	logic active;

	// accept when empty or when the held beat leaves this cycle
	assign in_ready = active & (~out_valid | out_ready);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			active    <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			active <= 1'b1;
			if (in_ready) begin
				out_valid <= in_valid;
			end
		end
	end

	// payload only moves on a transfer
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

// ==== logic/pixel_classify.sv ====
// colour is reported only for video pixels off the border, sop beats always pass through
module pixel_classify import imgproc_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  beat_t     beat,
	input  logic      fire,
	input  logic      mode,
	output beat_t     beat_out,
	output pix_info_t info
);

	coord_t       x, y;
	logic         video;
	logic [7:0]   r, g, b;
	logic [7:0]   v, vmin, diff, diff_div, v_div, s, h, grey;
	logic [15:0]  s_num;
	logic [17:0]  hue_num;
	logic [8:0]   hue_deg;
	logic         on_border;
	ball_colour_e colour;
	rgb_t         new_px;

	// exclusive bounds, value top may be inclusive
	function automatic logic in_range(input logic [7:0] hh, input logic [7:0] ss,
			input logic [7:0] vv, input hsv_range_t rng, input logic v_incl);
		logic h_ok;
		logic v_top;
		h_ok  = (rng.h_lo > rng.h_hi) ? (hh > rng.h_lo || hh < rng.h_hi)
			: (hh > rng.h_lo && hh < rng.h_hi);
		v_top = v_incl ? (vv <= rng.v_hi) : (vv < rng.v_hi);
		return h_ok && ss > rng.s_lo && ss < rng.s_hi && vv > rng.v_lo && v_top;
	endfunction

	assign r = beat.data.red;
	assign g = beat.data.green;
	assign b = beat.data.blue;

	////////////////////
	// coordinates
	////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x     <= '0;
			y     <= '0;
			video <= 1'b0;
		end else if (fire) begin
			if (beat.sop) begin
				x     <= '0;
				y     <= '0;
				// packet type lives in the low nibble of the header beat
				video <= (b[3:0] == 4'h0);
			end else if (x == coord_t'(image_w - 1)) begin
				x <= '0;
				y <= y + 11'd1;
			end else begin
				x <= x + 11'd1;
			end
		end
	end

	////////////////////
	// rgb to hsv
	////////////////////

	always_comb begin
		v = r;
		if (g > v) v = g;
		if (b > v) v = b;
		vmin = r;
		if (g < vmin) vmin = g;
		if (b < vmin) vmin = b;
		diff = v - vmin;
		// guard divisors, results are masked below anyway
		diff_div = (diff == 8'd0) ? 8'd1 : diff;
		v_div    = (v == 8'd0) ? 8'd1 : v;
		s_num = 16'd255 * 16'(diff);
		s     = (v == 8'd0) ? 8'd0 : 8'(s_num / 16'(v_div));
		// opencv sectors, each numerator already non-negative
		if (v == r) begin
			if (g >= b) hue_num = 18'd60 * 18'(g - b);
			else        hue_num = 18'd360 * 18'(diff) - 18'd60 * 18'(b - g);
		end else if (v == g) begin
			hue_num = 18'd120 * 18'(diff) + 18'd60 * 18'(b) - 18'd60 * 18'(r);
		end else begin
			hue_num = 18'd240 * 18'(diff) + 18'd60 * 18'(r) - 18'd60 * 18'(g);
		end
		hue_deg = 9'(hue_num / 18'(diff_div));
		// half-degree hue so it fits in a byte
		h = (diff == 8'd0) ? 8'd0 : 8'(hue_deg >> 1);
	end

	////////////////////
	// detection
	////////////////////

	always_comb begin
		// first match wins
		if (in_range(h, s, v, range_red, 1'b1))          colour = col_red;
		else if (in_range(h, s, v, range_green, 1'b0))   colour = col_green;
		else if (in_range(h, s, v, range_blue, 1'b0))    colour = col_blue;
		else if (in_range(h, s, v, range_violet, 1'b1))  colour = col_violet;
		else if (in_range(h, s, v, range_yellow, 1'b1))  colour = col_yellow;
		else                                             colour = col_none;
	end

	assign on_border = (x <= coord_t'(border_px)) || (x >= coord_t'(image_w - border_px))
		|| (y <= coord_t'(border_px)) || (y >= coord_t'(image_h - border_px));

	// grey = g/2 + r/4 + b/4
	assign grey = {1'b0, g[7:1]} + {2'b00, r[7:2]} + {2'b00, b[7:2]};

	always_comb begin
		if (!mode || beat.sop || !video) begin
			new_px = beat.data;
		end else if (on_border) begin
			new_px = '{grey, grey, grey};
		end else begin
			case (colour)
				col_red:    new_px = high_red;
				col_green:  new_px = high_green;
				col_blue:   new_px = high_blue;
				col_violet: new_px = high_violet;
				col_yellow: new_px = high_yellow;
				default:    new_px = '{grey, grey, grey};
			endcase
		end
	end

	assign beat_out = '{data: new_px, sop: beat.sop, eop: beat.eop};

	// tracker only sees colours that would be highlighted
	assign info = '{fire: fire, sop: beat.sop, eop: beat.eop, video: video, x: x, y: y,
		colour: (on_border || beat.sop || !video) ? col_none : colour};

endmodule

// ==== logic/box_tracker.sv ====
// reports use the boxes latched at the last video eop, a frame is skipped if the buffer lacks room
module box_tracker import imgproc_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  pix_info_t  info,
	input  msg_count_t msg_count,
	output logic       msg_wr,
	output msg_word_t  msg_word
);

	box_t       run_box [n_colours];
	box_t       lat_box [n_colours];
	logic [2:0] hit_idx;
	logic [2:0] col_idx;
	logic [2:0] frame_cnt;
	logic       eop_fire;
	logic       room;
	msg_phase_e phase;

	// box slot for the classified colour
	assign hit_idx  = 3'(info.colour) - 3'd1;
	assign eop_fire = info.fire && info.eop && info.video;
	// a full report is fifteen words
	assign room     = msg_count < msg_count_t'(msg_depth - 15);

	////////////////////
	// bounding boxes
	////////////////////

	always_ff @(posedge clk) begin
		if (info.fire && info.sop) begin
			for (int i = 0; i < n_colours; i++) begin
				run_box[i] <= '{xmin: coord_t'(image_w - 1), ymin: coord_t'(image_h - 1),
					xmax: '0, ymax: '0};
			end
		end else if (info.fire && info.colour != col_none) begin
			if (info.x < run_box[hit_idx].xmin) run_box[hit_idx].xmin <= info.x;
			if (info.x > run_box[hit_idx].xmax) run_box[hit_idx].xmax <= info.x;
			if (info.y < run_box[hit_idx].ymin) run_box[hit_idx].ymin <= info.y;
			// rows arrive in order, so the last y is the largest
			run_box[hit_idx].ymax <= info.y;
		end
		if (eop_fire) begin
			lat_box <= run_box;
		end
	end

	////////////////////
	// report writer
	////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= '0;
			phase     <= phase_idle;
			col_idx   <= '0;
		end else begin
			if (eop_fire) begin
				if (frame_cnt != 3'd0) begin
					frame_cnt <= frame_cnt - 3'd1;
				end else if (room && phase == phase_idle) begin
					frame_cnt <= 3'(msg_interval - 1);
				end
			end
			case (phase)
				phase_idle: begin
					if (eop_fire && frame_cnt == 3'd0 && room) begin
						phase   <= phase_id;
						col_idx <= '0;
					end
				end
				phase_id:       phase <= phase_top_left;
				phase_top_left: phase <= phase_bottom_right;
				default: begin
					// three words per colour, stop after yellow
					if (col_idx == 3'(n_colours - 1)) begin
						phase <= phase_idle;
					end else begin
						phase   <= phase_id;
						col_idx <= col_idx + 3'd1;
					end
				end
			endcase
		end
	end

	assign msg_wr = (phase != phase_idle);

	always_comb begin
		case (phase)
			phase_id: begin
				case (col_idx)
					3'd0:    msg_word = {8'h00, "RBB"};
					3'd1:    msg_word = {8'h00, "GBB"};
					3'd2:    msg_word = {8'h00, "BBB"};
					3'd3:    msg_word = {8'h00, "VBB"};
					default: msg_word = {8'h00, "YBB"};
				endcase
			end
			phase_top_left:
				msg_word = {5'b0, lat_box[col_idx].xmin, 5'b0, lat_box[col_idx].ymin};
			phase_bottom_right:
				msg_word = {5'b0, lat_box[col_idx].xmax, 5'b0, lat_box[col_idx].ymax};
			default:
				msg_word = '0;
		endcase
	end

endmodule

// ==== logic/msg_fifo.sv ====
// writes to a full buffer are dropped, pops of an empty buffer are ignored
module msg_fifo import imgproc_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       clear,
	input  logic       wr,
	input  msg_word_t  wr_word,
	input  logic       pop,
	output msg_word_t  head,
	output msg_count_t count,
	output logic       empty
);

	msg_word_t            mem [msg_depth];
	logic [msg_ptr_w-1:0] wr_ptr, rd_ptr;
	logic                 do_wr, do_pop;

	assign empty  = (count == '0);
	assign do_wr  = wr && (count != msg_count_t'(msg_depth));
	assign do_pop = pop && !empty;

	// show-ahead, head is the oldest word
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset_n || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			count <= count + msg_count_t'(do_wr) - msg_count_t'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_word;
		end
	end

endmodule

// ==== logic/reg_port.sv ====
// readdata is registered, a message read pops the buffer once per read burst
module reg_port import imgproc_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        s_chipselect,
	input  logic        s_read,
	input  logic        s_write,
	input  logic [2:0]  s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata,
	input  msg_word_t   msg_head,
	input  msg_count_t  msg_count,
	input  logic        msg_empty,
	output logic        msg_pop,
	output logic        msg_flush
);

	logic [7:0] status_reg;
	// read strobe of the previous cycle
	logic       read_d;
	logic       rd_sel, wr_sel;

	assign rd_sel = s_chipselect & s_read;
	assign wr_sel = s_chipselect & s_write;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			status_reg <= '0;
			s_readdata <= '0;
			read_d     <= 1'b0;
		end else begin
			if (wr_sel && s_address == addr_status) begin
				status_reg <= s_writedata[7:0];
			end
			if (rd_sel) begin
				case (s_address)
					addr_status: s_readdata <= {16'b0, msg_count, status_reg};
					addr_msg:    s_readdata <= msg_head;
					addr_id:     s_readdata <= core_id;
					default:     s_readdata <= '0;
				endcase
			end
			read_d <= rd_sel;
		end
	end

	// advance only on the first cycle of a read
	assign msg_pop = rd_sel & ~read_d & ~msg_empty & (s_address == addr_msg);

	// bit 4 of a status write empties the buffer
	assign msg_flush = wr_sel & (s_address == addr_status) & s_writedata[flush_bit];

endmodule

// ==== logic/eee_imgproc.sv ====
// two-stage stream pipeline, the classifier sits between the stages and feeds the tracker
module eee_imgproc import imgproc_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	// register port
	input  logic        s_chipselect,
	input  logic        s_read,
	input  logic        s_write,
	output logic [31:0] s_readdata,
	input  logic [31:0] s_writedata,
	input  logic [2:0]  s_address,
	// stream sink
	input  rgb_t        sink_data,
	input  logic        sink_valid,
	output logic        sink_ready,
	input  logic        sink_sop,
	input  logic        sink_eop,
	// stream source
	output rgb_t        source_data,
	output logic        source_valid,
	input  logic        source_ready,
	output logic        source_sop,
	output logic        source_eop,
	// highlight enable
	input  logic        mode
);

	beat_t      in_beat, cls_beat;
	logic       in_valid, out_ready;
	pix_info_t  info;
	logic       msg_wr, msg_pop, msg_flush, msg_empty;
	msg_word_t  msg_word, msg_head;
	msg_count_t msg_count;

	////////////////////
	// stream path
	////////////////////

	stream_stage in_stage (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_data   ({sink_data, sink_sop, sink_eop}),
		.in_valid  (sink_valid),
		.in_ready  (sink_ready),
		.out_data  (in_beat),
		.out_valid (in_valid),
		.out_ready (out_ready)
	);

	// fire is a transfer between the two stages
	pixel_classify pixel_classify_inst (
		.clk      (clk),
		.reset_n  (reset_n),
		.beat     (in_beat),
		.fire     (in_valid & out_ready),
		.mode     (mode),
		.beat_out (cls_beat),
		.info     (info)
	);

	stream_stage out_stage (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_data   (cls_beat),
		.in_valid  (in_valid),
		.in_ready  (out_ready),
		.out_data  ({source_data, source_sop, source_eop}),
		.out_valid (source_valid),
		.out_ready (source_ready)
	);

	////////////////////
	// reports
	////////////////////

	box_tracker box_tracker_inst (
		.clk       (clk),
		.reset_n   (reset_n),
		.info      (info),
		.msg_count (msg_count),
		.msg_wr    (msg_wr),
		.msg_word  (msg_word)
	);

	msg_fifo msg_fifo_inst (
		.clk     (clk),
		.reset_n (reset_n),
		.clear   (msg_flush),
		.wr      (msg_wr),
		.wr_word (msg_word),
		.pop     (msg_pop),
		.head    (msg_head),
		.count   (msg_count),
		.empty   (msg_empty)
	);

	reg_port reg_port_inst (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_writedata  (s_writedata),
		.s_readdata   (s_readdata),
		.msg_head     (msg_head),
		.msg_count    (msg_count),
		.msg_empty    (msg_empty),
		.msg_pop      (msg_pop),
		.msg_flush    (msg_flush)
	);

endmodule

// ==== verification/eee_imgproc_chk.sv ====
// stream port checks only, assumes one sop beat at most between sink and source
module eee_imgproc_chk import imgproc_pkg::*; (
	input logic clk,
	input logic reset_n,
	input rgb_t sink_data,
	input logic sink_valid,
	input logic sink_ready,
	input logic sink_sop,
	input logic sink_eop,
	input rgb_t source_data,
	input logic source_valid,
	input logic source_ready,
	input logic source_sop,
	input logic source_eop,
	input logic mode
);

	timeunit 1ns;
	timeprecision 1ps;

	// failed assertions so far, read by the testbench
	int    fail_count = 0;
	beat_t sink_beat;
	beat_t source_beat;
	logic  sink_fire;
	// last header that entered the sink
	rgb_t  sop_data;

	assign sink_beat   = '{data: sink_data, sop: sink_sop, eop: sink_eop};
	assign source_beat = '{data: source_data, sop: source_sop, eop: source_eop};
	assign sink_fire   = sink_valid & sink_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			sop_data <= '0;
		end else if (sink_fire && sink_sop) begin
			sop_data <= sink_data;
		end
	end

	////////////////////
	// stream properties
	////////////////////

	// open path in mode low, two cycles from sink to source
	passthrough_a: assert property (@(posedge clk) disable iff (!reset_n)
		$past(sink_fire && !mode && source_ready, 2) && $past(source_ready && !mode)
		|-> source_valid && source_beat == $past(sink_beat, 2))
	else begin
		fail_count++;
		$error("source beat differs from the sink beat two cycles earlier");
	end

	// a stalled beat must not change
	stall_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
		$past(source_valid && !source_ready) |-> source_valid && $stable(source_beat))
	else begin
		fail_count++;
		$error("source beat changed while stalled");
	end

	// headers are never recoloured
	sop_pass_a: assert property (@(posedge clk) disable iff (!reset_n)
		source_valid && source_ready && source_sop |-> source_data == sop_data)
	else begin
		fail_count++;
		$error("sop beat left the source altered");
	end

endmodule

// ==== verification/eee_imgproc_tb.sv ====
// one 640x480 frame is about 400k clocks, the result also needs the bound stream checker
module eee_imgproc_tb import imgproc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// green ball block, well inside the frame
	localparam int   blk_x0      = 200;
	localparam int   blk_x1      = 259;
	localparam int   blk_y0      = 100;
	localparam int   blk_y1      = 149;
	// left strip of ball pixels, it lies on the border
	localparam int   strip_w     = 8;
	// h 68, s 178, v 100 falls inside the green range
	localparam rgb_t ball_px     = 24'h1e6432;
	localparam rgb_t green_out   = 24'h00ff00;
	localparam int   short_len   = 300;
	localparam int   beat_limit  = 1000;
	localparam int   drain_limit = 1000;
	localparam int   poll_limit  = 100;

	logic        clk;
	logic        reset_n;
	logic        s_chipselect;
	logic        s_read;
	logic        s_write;
	logic [2:0]  s_address;
	logic [31:0] s_writedata;
	logic [31:0] s_readdata;
	rgb_t        sink_data;
	logic        sink_valid;
	logic        sink_ready;
	logic        sink_sop;
	logic        sink_eop;
	rgb_t        source_data;
	logic        source_valid;
	logic        source_ready;
	logic        source_sop;
	logic        source_eop;
	logic        mode;

	integer seed = 85417;
	int     check_errors = 0;
	int     timeouts = 0;
	logic   ready_random = 1'b0;
	string  test_name = "reset";
	// beats expected at the source, in order
	beat_t  exp_q [$];

	eee_imgproc eee_imgproc_inst (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_readdata   (s_readdata),
		.s_writedata  (s_writedata),
		.s_address    (s_address),
		.sink_data    (sink_data),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.source_data  (source_data),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.mode         (mode)
	);

	bind eee_imgproc eee_imgproc_chk chk_inst (
		.clk          (clk),
		.reset_n      (reset_n),
		.sink_data    (sink_data),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.source_data  (source_data),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.mode         (mode)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// closing report
	////////////////////

	task automatic close_run();
		int assert_errors;
		assert_errors = eee_imgproc_inst.chk_inst.fail_count;
		$display("errors: %0d checks, %0d assertions, %0d timeouts",
			check_errors, assert_errors, timeouts);
		if (check_errors == 0 && assert_errors == 0 && timeouts == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("timeout in %s: %s", test_name, what);
		timeouts++;
		close_run();
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			check_errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, got);
		end
	endtask

	////////////////////
	// pixel rules
	////////////////////

	// g/2 + r/4 + b/4 on every channel
	function automatic rgb_t grey_of(input rgb_t px);
		logic [7:0] gy;
		gy = px.green / 2 + px.red / 4 + px.blue / 4;
		return '{gy, gy, gy};
	endfunction

	function automatic rgb_t random_pixel();
		logic [31:0] r;
		r = $random(seed);
		return r[23:0];
	endfunction

	// dark background, v stays under every range's lower bound
	function automatic rgb_t frame_pixel(input int x, input int y);
		logic [31:0] r;
		if ((x >= blk_x0 && x <= blk_x1 && y >= blk_y0 && y <= blk_y1) || x < strip_w) begin
			return ball_px;
		end
		r = $random(seed);
		return {4'h0, r[3:0], 4'h0, r[7:4], 4'h0, r[11:8]};
	endfunction

	function automatic rgb_t expect_pixel(input rgb_t px, input int x, input int y,
			input logic video_pkt);
		if (!mode || !video_pkt) begin
			return px;
		end
		if (x <= border_px || x >= image_w - border_px || y <= border_px
				|| y >= image_h - border_px) begin
			return grey_of(px);
		end
		if (px == ball_px) begin
			return green_out;
		end
		return grey_of(px);
	endfunction

	// ascii id in the low three bytes
	function automatic logic [31:0] id_word(input int c);
		string names;
		names = "RGBVY";
		return {8'h00, names[c], "BB"};
	endfunction

	function automatic logic [31:0] box_word(input int x, input int y);
		return {5'b0, 11'(x), 5'b0, 11'(y)};
	endfunction

	////////////////////
	// stream driver
	////////////////////

	task automatic send_beat(input beat_t bt, input beat_t exp_bt);
		int n;
		// occasional idle cycle before the beat
		if (($random(seed) & 3) == 0) begin
			@(negedge clk);
		end
		{sink_data, sink_sop, sink_eop} = bt;
		sink_valid = 1'b1;
		n = 0;
		// sink_ready follows source_ready, which also changes on the falling edge
		#1;
		while (!sink_ready) begin
			if (n == beat_limit) begin
				report_timeout("sink_ready stayed low");
			end
			@(negedge clk);
			#1;
			n++;
		end
		// ready is stable here, the beat moves at the next rising edge
		exp_q.push_back(exp_bt);
		@(negedge clk);
		sink_valid = 1'b0;
	endtask

	task automatic send_packet(input logic video_pkt, input int n_pix);
		rgb_t  px;
		beat_t bt;
		int    x;
		int    y;
		// header, low blue nibble zero marks video
		bt = beat_t'{data: video_pkt ? 24'h123450 : 24'h123455, sop: 1'b1, eop: 1'b0};
		send_beat(bt, bt);
		for (int i = 0; i < n_pix; i++) begin
			x = i % image_w;
			y = i / image_w;
			px = video_pkt ? frame_pixel(x, y) : random_pixel();
			bt = beat_t'{data: px, sop: 1'b0, eop: (i == n_pix - 1)};
			send_beat(bt, beat_t'{data: expect_pixel(px, x, y, video_pkt), sop: 1'b0,
				eop: bt.eop});
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 || source_valid) begin
			if (n == drain_limit) begin
				report_timeout("stream did not drain");
			end
			@(negedge clk);
			n++;
		end
	endtask

	////////////////////
	// register port
	////////////////////

	task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
		s_chipselect = 1'b1;
		s_read       = 1'b1;
		s_address    = addr;
		@(negedge clk);
		data = s_readdata;
		s_chipselect = 1'b0;
		s_read       = 1'b0;
		// idle cycle so the next message read pops again
		@(negedge clk);
	endtask

	task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
		s_chipselect = 1'b1;
		s_write      = 1'b1;
		s_address    = addr;
		s_writedata  = data;
		@(negedge clk);
		s_chipselect = 1'b0;
		s_write      = 1'b0;
	endtask

	// poll status until a full report sits in the buffer
	task automatic wait_report(output logic [31:0] status);
		int n;
		n = 0;
		read_reg(addr_status, status);
		while (status[15:8] < 8'd15) begin
			if (n == poll_limit) begin
				report_timeout("report never reached the message buffer");
			end
			read_reg(addr_status, status);
			n++;
		end
	endtask

	////////////////////
	// source monitor
	////////////////////

	initial begin
		beat_t exp_bt;
		beat_t got;
		source_ready = 1'b0;
		forever begin
			@(negedge clk);
			source_ready = ready_random ? (($random(seed) & 3) != 0) : 1'b1;
			// valid and ready both stable, so the beat leaves at the next edge
			if (reset_n && source_valid && source_ready) begin
				got = '{data: source_data, sop: source_sop, eop: source_eop};
				if (exp_q.size() == 0) begin
					check_errors++;
					$display("source sent a beat that was never driven into the sink");
				end else begin
					exp_bt = exp_q.pop_front();
					assert (got == exp_bt) else begin
						check_errors++;
						$display("CHECK FAILED %s: expected %h, actual %h", test_name, exp_bt, got);
					end
				end
			end
		end
	end

	////////////////////
	// test sequence
	////////////////////

	initial begin
		logic [31:0] word;
		reset_n      = 1'b0;
		s_chipselect = 1'b0;
		s_read       = 1'b0;
		s_write      = 1'b0;
		s_address    = '0;
		s_writedata  = '0;
		sink_data    = '0;
		sink_valid   = 1'b0;
		sink_sop     = 1'b0;
		sink_eop     = 1'b0;
		mode         = 1'b0;
		repeat (8) @(negedge clk);
		// both handshake outputs stay low during reset
		check_word("reset sink_ready", 32'd0, 32'(sink_ready));
		check_word("reset source_valid", 32'd0, 32'(source_valid));
		reset_n = 1'b1;
		@(negedge clk);
		check_word("sink_ready after reset", 32'd1, 32'(sink_ready));

		test_name = "core id";
		read_reg(addr_id, word);
		check_word(test_name, 32'h1234eee2, word);

		// passthrough under random back-pressure
		test_name    = "passthrough";
		ready_random = 1'b1;
		send_packet(1'b0, short_len);
		wait_drain();

		// non-video stays unchanged in highlight mode and is never reported
		test_name = "non-video packet";
		mode      = 1'b1;
		send_packet(1'b0, short_len);
		wait_drain();
		read_reg(addr_status, word);
		check_word("non-video report count", 32'd0, 32'(word[15:8]));

		test_name    = "video highlight";
		ready_random = 1'b0;
		send_packet(1'b1, image_w * image_h);
		wait_drain();

		test_name = "report";
		wait_report(word);
		check_word("report count", 32'd15, 32'(word[15:8]));
		// red first, only green holds a box
		for (int c = 0; c < n_colours; c++) begin
			read_reg(addr_msg, word);
			check_word("report id", id_word(c), word);
			read_reg(addr_msg, word);
			check_word("report top-left", (c == 1) ? box_word(blk_x0, blk_y0)
				: box_word(image_w - 1, image_h - 1), word);
			read_reg(addr_msg, word);
			check_word("report bottom-right", (c == 1) ? box_word(blk_x1, blk_y1)
				: box_word(0, 0), word);
		end
		read_reg(addr_status, word);
		check_word("count after reads", 32'd0, 32'(word[15:8]));

		// five more video packets fall inside the interval, the sixth reports again
		test_name = "report interval";
		repeat (5) begin
			send_packet(1'b1, short_len);
		end
		wait_drain();
		read_reg(addr_status, word);
		check_word("count within interval", 32'd0, 32'(word[15:8]));
		send_packet(1'b1, short_len);
		wait_drain();
		wait_report(word);
		check_word("count before flush", 32'd15, 32'(word[15:8]));

		// status byte keeps the written value, count goes to zero
		test_name = "flush";
		write_reg(addr_status, 32'h0000_0010);
		read_reg(addr_status, word);
		check_word(test_name, 32'h0000_0010, word);

		close_run();
	end

endmodule

// ==== verilog.f ====
logic/imgproc_pkg.sv
logic/stream_stage.sv
logic/pixel_classify.sv
logic/box_tracker.sv
logic/msg_fifo.sv
logic/reg_port.sv
logic/eee_imgproc.sv
verification/eee_imgproc_chk.sv
verification/eee_imgproc_tb.sv

// ==== Makefile ====
VERILATOR   = verilator
TOP         = eee_imgproc_tb
FILELIST    = verilog.f
OBJ_DIR     = obj_dir
LOG         = sim.log
COMMON      = --timing --assert --timescale 1ns/1ps --top-module $(TOP)
BUILD_FLAGS = --binary $(COMMON) --Mdir $(OBJ_DIR)
LINT_FLAGS  = --lint-only $(COMMON)
RUN_FLAGS   = +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
